/* compile.f */
source/img_geom_pkg.sv
source/conv_ctrl_pkg.sv
source/pixel_loader.sv
source/image_buffer.sv
source/window_scanner.sv
source/conv_mac.sv
source/conv_core.sv
tb/clk_gen.sv
tb/conv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_core_tb -f compile.f -o conv_core_sim
./obj_dir/conv_core_sim > sim.log
cat sim.log

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
echo "Simulation reported failure, see sim.log"
exit 1

/* source/conv_core.sv */
module conv_core #(
	parameter int STRIDE   = 1,
	parameter int DILATION = 2
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_in_valid,
	input  img_geom_pkg::word_t      i_in_data,
	output logic                     o_in_ready,
	output logic                     o_out_valid,
	output img_geom_pkg::pixel_t     o_out_data,
	output img_geom_pkg::out_addr_t  o_out_addr,
	output logic                     o_exe_finish
);

	import img_geom_pkg::*;
	import conv_ctrl_pkg::*;

	phase_t               phase_r;
	phase_t               phase_next;
	logic [1:0]           wei_cnt_r;
	logic                 accept;
	logic                 load_en;
	logic                 wei_en;
	logic                 last_wei;
	logic                 scan_start;
	logic                 image_done;
	logic                 scan_done;
	logic [NUM_BANKS-1:0] wr_en;
	bank_addr_t           wr_addr;
	pixel_t [3:0]         wr_pixels;
	logic                 rd_en;
	coord_t               rd_row;
	coord_t [2:0]         rd_cols;
	pixel_t [2:0]         rd_pixels;
	logic                 tap_valid;
	tap_row_t             tap_row;
	logic [2:0]           pad;
	out_addr_t            res_addr;

	// ==================================================
	// Word routing
	// ==================================================
	assign accept = i_in_valid && o_in_ready;

	// A word taken while the last image strobe is out is already a weight
	assign load_en    = accept && ((phase_r == PH_IDLE) || ((phase_r == PH_IMAGE) && !image_done));
	assign wei_en     = accept && ((phase_r == PH_WEIGHT) || ((phase_r == PH_IMAGE) && image_done));
	assign last_wei   = wei_en && (wei_cnt_r == 2'(WEIGHT_WORDS - 1));
	assign scan_start = (phase_r == PH_WEIGHT) && last_wei;

	always_comb begin
		phase_next = phase_r;
		case (phase_r)
			PH_IDLE:   if (accept)     phase_next = PH_IMAGE;
			PH_IMAGE:  if (image_done) phase_next = PH_WEIGHT;
			PH_WEIGHT: if (last_wei)   phase_next = PH_CONV;
			PH_CONV:   if (scan_done)  phase_next = PH_DONE;
			PH_DONE:   phase_next = PH_DONE;
			default:   phase_next = PH_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_r      <= PH_IDLE;
			wei_cnt_r    <= '0;
			o_in_ready   <= 1'b0;
			o_exe_finish <= 1'b0;
		end else begin
			phase_r <= phase_next;
			if (wei_en) begin
				wei_cnt_r <= wei_cnt_r + 2'd1;
			end
			if (last_wei) begin
				o_in_ready <= 1'b0;
			end else if (phase_r == PH_IDLE) begin
				o_in_ready <= 1'b1;
			end
			// Sticky until reset
			if ((phase_r == PH_CONV) && scan_done) begin
				o_exe_finish <= 1'b1;
			end
		end
	end

	// ==================================================
	// Datapath peers
	// ==================================================
	pixel_loader u_loader (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_load_en(load_en), .i_word(i_in_data),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_pixels(wr_pixels),
		.o_image_done(image_done)
	);

	image_buffer u_buffer (
		.i_clk(i_clk), .i_phase(phase_r), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
		.i_wr_pixels(wr_pixels), .i_rd_en(rd_en), .i_rd_row(rd_row),
		.i_rd_cols(rd_cols), .o_rd_pixels(rd_pixels)
	);

	window_scanner #(.STRIDE(STRIDE), .DILATION(DILATION)) u_scanner (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(scan_start),
		.o_rd_en(rd_en), .o_rd_row(rd_row), .o_rd_cols(rd_cols),
		.o_tap_valid(tap_valid), .o_tap_row(tap_row), .o_pad(pad),
		.o_res_addr(res_addr), .o_scan_done(scan_done)
	);

	conv_mac u_mac (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wei_en(wei_en), .i_word(i_in_data),
		.i_tap_valid(tap_valid), .i_tap_row(tap_row), .i_pad(pad),
		.i_res_addr(res_addr), .i_pixels(rd_pixels),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .o_out_addr(o_out_addr)
	);

endmodule

/* source/conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

	// ==================================================
	// Phases of one run
	// ==================================================
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_IMAGE,
		PH_WEIGHT,
		PH_CONV,
		PH_DONE
	} phase_t;

	// Words after the image, taps per window
	localparam int WEIGHT_WORDS = 3;
	localparam int NUM_TAPS     = 9;

	// ==================================================
	// Fixed-point result conversion
	// ==================================================
	localparam int ROUND_BIAS = 64;
	localparam int FRAC_SHIFT = 7;
	localparam int PIX_MAX    = 255;

	typedef logic signed [7:0]  weight_t;
	typedef logic signed [19:0] acc_t;

	// Window row 0..2
	typedef logic [1:0] tap_row_t;

endpackage

/* source/conv_mac.sv */
module conv_mac (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_wei_en,
	input  img_geom_pkg::word_t         i_word,
	input  logic                        i_tap_valid,
	input  conv_ctrl_pkg::tap_row_t     i_tap_row,
	input  logic [2:0]                  i_pad,
	input  img_geom_pkg::out_addr_t     i_res_addr,
	input  img_geom_pkg::pixel_t [2:0]  i_pixels,
	output logic                        o_out_valid,
	output img_geom_pkg::pixel_t        o_out_data,
	output img_geom_pkg::out_addr_t     o_out_addr
);

	import img_geom_pkg::*;
	import conv_ctrl_pkg::*;

	word_t   wei_word [WEIGHT_WORDS];
	weight_t taps [NUM_TAPS];
	pixel_t  pix;
	acc_t    acc_r;
	acc_t    row_sum;
	acc_t    total;
	acc_t    rounded;
	acc_t    shifted;
	pixel_t  clamped;

	// ==================================================
	// Weight store
	// ==================================================
	// Shift in three words, the first ends up in slot 0
	always_ff @(posedge i_clk) begin
		if (i_wei_en) begin
			wei_word[WEIGHT_WORDS-1] <= i_word;
			for (int w = 0; w < WEIGHT_WORDS - 1; w++) begin
				wei_word[w] <= wei_word[w + 1];
			end
		end
	end

	// Row-major taps, top byte first within a word
	always_comb begin
		for (int n = 0; n < NUM_TAPS; n++) begin
			taps[n] = weight_t'(wei_word[n / PIX_PER_WORD][31 - 8 * (n % PIX_PER_WORD) -: 8]);
		end
	end

	// ==================================================
	// One window row per cycle
	// ==================================================
	always_comb begin
		row_sum = '0;
		pix     = '0;
		for (int j = 0; j < 3; j++) begin
			pix     = i_pad[j] ? '0 : i_pixels[j];
			row_sum = row_sum + $signed({1'b0, pix}) * taps[3 * i_tap_row + j];
		end
	end

	assign total   = ((i_tap_row == 2'd0) ? acc_t'(0) : acc_r) + row_sum;
	assign rounded = total + acc_t'(ROUND_BIAS);
	assign shifted = rounded >>> FRAC_SHIFT;

	// Saturate to the pixel range
	always_comb begin
		if (shifted < 0) begin
			clamped = '0;
		end else if (shifted > PIX_MAX) begin
			clamped = pixel_t'(PIX_MAX);
		end else begin
			clamped = shifted[7:0];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= i_tap_valid && (i_tap_row == 2'd2);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_tap_valid) begin
			acc_r <= total;
			if (i_tap_row == 2'd2) begin
				o_out_data <= clamped;
				o_out_addr <= i_res_addr;
			end
		end
	end

	a_tap_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tap_valid && (i_tap_row != 2'd2) |=>
		i_tap_valid && (i_tap_row == $past(i_tap_row) + 2'd1));

endmodule

/* source/image_buffer.sv */
module image_buffer (
	input  logic                          i_clk,
	input  conv_ctrl_pkg::phase_t         i_phase,
	input  logic [img_geom_pkg::NUM_BANKS-1:0] i_wr_en,
	input  img_geom_pkg::bank_addr_t      i_wr_addr,
	input  img_geom_pkg::pixel_t [3:0]    i_wr_pixels,
	input  logic                          i_rd_en,
	input  img_geom_pkg::coord_t          i_rd_row,
	input  img_geom_pkg::coord_t [2:0]    i_rd_cols,
	output img_geom_pkg::pixel_t [2:0]    o_rd_pixels
);

	import img_geom_pkg::*;
	import conv_ctrl_pkg::*;

	pixel_t               mem [NUM_BANKS][BANK_DEPTH];
	pixel_t               bank_q [NUM_BANKS];
	bank_addr_t           bank_raddr [NUM_BANKS];
	logic [BANK_BITS-1:0] sel_q [3];
	logic                 wr_grant;
	logic                 rd_grant;

	// Port select by phase
	assign wr_grant = (i_phase == PH_IMAGE);
	assign rd_grant = (i_phase == PH_CONV) && i_rd_en;

	// Route each column's address to the bank that holds it
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_raddr[b] = '0;
			for (int j = 0; j < 3; j++) begin
				if (i_rd_cols[j][BANK_BITS-1:0] == BANK_BITS'(b)) begin
					bank_raddr[b] = {i_rd_row, i_rd_cols[j][$bits(coord_t)-1:BANK_BITS]};
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (wr_grant && i_wr_en[b]) begin
				mem[b][i_wr_addr] <= i_wr_pixels[b % PIX_PER_WORD];
			end
			if (rd_grant) begin
				bank_q[b] <= mem[b][bank_raddr[b]];
			end
		end
		if (rd_grant) begin
			for (int j = 0; j < 3; j++) begin
				sel_q[j] <= i_rd_cols[j][BANK_BITS-1:0];
			end
		end
	end

	// Left, centre, right
	always_comb begin
		for (int j = 0; j < 3; j++) begin
			o_rd_pixels[j] = bank_q[sel_q[j]];
		end
	end

	a_wr_only_in_image: assert property (@(posedge i_clk) (|i_wr_en) |-> (i_phase == PH_IMAGE));

endmodule

/* source/img_geom_pkg.sv */
package img_geom_pkg;

	// ==================================================
	// Image geometry
	// ==================================================
	localparam int IMG_DIM      = 64;
	localparam int PIX_PER_WORD = 4;
	localparam int IMG_WORDS    = IMG_DIM * IMG_DIM / PIX_PER_WORD;

	// ==================================================
	// Bank mapping
	// ==================================================
	// Pixel (r, c) sits in bank c mod 8 at address r*8 + c/8
	localparam int NUM_BANKS  = 8;
	localparam int BANK_DEPTH = IMG_DIM * IMG_DIM / NUM_BANKS;
	localparam int BANK_BITS  = $clog2(NUM_BANKS);

	// ==================================================
	// Types
	// ==================================================
	typedef logic [7:0]  pixel_t;
	typedef logic [5:0]  coord_t;
	typedef logic [8:0]  bank_addr_t;
	typedef logic [31:0] word_t;

	// Row in the upper six bits, column in the lower six
	typedef logic [11:0] out_addr_t;

endpackage

/* source/pixel_loader.sv */
module pixel_loader (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_load_en,
	input  img_geom_pkg::word_t                 i_word,
	output logic [img_geom_pkg::NUM_BANKS-1:0]  o_wr_en,
	output img_geom_pkg::bank_addr_t            o_wr_addr,
	output img_geom_pkg::pixel_t [3:0]          o_wr_pixels,
	output logic                                o_image_done
);

	import img_geom_pkg::*;

	logic [$clog2(IMG_WORDS)-1:0] word_cnt_r;
	logic [NUM_BANKS-1:0]         lane_mask;

	// Even words feed banks 0-3, odd words banks 4-7
	always_comb begin
		lane_mask = '0;
		for (int i = 0; i < PIX_PER_WORD; i++) begin
			lane_mask[word_cnt_r[0] * PIX_PER_WORD + i] = 1'b1;
		end
	end

	// ==================================================
	// Word counter and write strobes
	// ==================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			word_cnt_r   <= '0;
			o_wr_en      <= '0;
			o_image_done <= 1'b0;
		end else begin
			o_wr_en      <= i_load_en ? lane_mask : '0;
			o_image_done <= i_load_en && (word_cnt_r == IMG_WORDS - 1);
			if (i_load_en) begin
				word_cnt_r <= word_cnt_r + 1'b1;
			end
		end
	end

	// Address advances once per pair of words
	always_ff @(posedge i_clk) begin
		if (i_load_en) begin
			o_wr_addr <= bank_addr_t'(word_cnt_r >> 1);
			for (int i = 0; i < PIX_PER_WORD; i++) begin
				// Leftmost pixel in the top byte
				o_wr_pixels[i] <= i_word[31 - 8 * i -: 8];
			end
		end
	end

endmodule

/* source/window_scanner.sv */
module window_scanner #(
	parameter int STRIDE   = 1,
	parameter int DILATION = 2
) (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_start,
	output logic                         o_rd_en,
	output img_geom_pkg::coord_t         o_rd_row,
	output img_geom_pkg::coord_t [2:0]   o_rd_cols,
	output logic                         o_tap_valid,
	output conv_ctrl_pkg::tap_row_t      o_tap_row,
	output logic [2:0]                   o_pad,
	output img_geom_pkg::out_addr_t      o_res_addr,
	output logic                         o_scan_done
);

	import img_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam logic signed [7:0] DIL_S = 8'(DILATION);

	logic                    active_r;
	tap_row_t                tap_r;
	coord_t                  row_r;
	coord_t                  col_r;
	logic                    last_rd_r;
	logic [6:0]              row_step;
	logic [6:0]              col_step;
	logic                    last_row;
	logic                    last_col;
	logic                    last_read;
	logic signed [7:0]       row_pos;
	logic signed [7:0]       col_pos [3];
	logic [2:0]              pad;

	function automatic logic out_of_image(input logic signed [7:0] pos);
		return (pos < 0) || (pos > IMG_DIM - 1);
	endfunction

	function automatic coord_t clamp_idx(input logic signed [7:0] pos);
		if (pos < 0) begin
			return '0;
		end
		if (pos > IMG_DIM - 1) begin
			return coord_t'(IMG_DIM - 1);
		end
		return pos[5:0];
	endfunction

	// ==================================================
	// Position stepping
	// ==================================================
	assign row_step  = {1'b0, row_r} + 7'(STRIDE);
	assign col_step  = {1'b0, col_r} + 7'(STRIDE);
	assign last_row  = (row_step >= 7'(IMG_DIM));
	assign last_col  = (col_step >= 7'(IMG_DIM));
	assign last_read = (tap_r == 2'd2) && last_row && last_col;

	// Rows are the inner loop
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active_r  <= 1'b0;
			tap_r     <= '0;
			row_r     <= '0;
			col_r     <= '0;
			last_rd_r <= 1'b0;
		end else begin
			last_rd_r <= active_r && last_read;
			if (i_start && !active_r) begin
				active_r <= 1'b1;
				tap_r    <= '0;
				row_r    <= '0;
				col_r    <= '0;
			end else if (active_r) begin
				if (tap_r == 2'd2) begin
					tap_r <= '0;
					if (last_row) begin
						row_r <= '0;
						if (last_col) begin
							active_r <= 1'b0;
						end else begin
							col_r <= col_step[5:0];
						end
					end else begin
						row_r <= row_step[5:0];
					end
				end else begin
					tap_r <= tap_r + 2'd1;
				end
			end
		end
	end

	// ==================================================
	// Window coordinates and zero padding
	// ==================================================
	always_comb begin
		case (tap_r)
			2'd0:    row_pos = $signed({2'b0, row_r}) - DIL_S;
			2'd1:    row_pos = $signed({2'b0, row_r});
			default: row_pos = $signed({2'b0, row_r}) + DIL_S;
		endcase
		col_pos[0] = $signed({2'b0, col_r}) - DIL_S;
		col_pos[1] = $signed({2'b0, col_r});
		col_pos[2] = $signed({2'b0, col_r}) + DIL_S;
		for (int j = 0; j < 3; j++) begin
			pad[j]       = out_of_image(row_pos) || out_of_image(col_pos[j]);
			o_rd_cols[j] = clamp_idx(col_pos[j]);
		end
	end

	assign o_rd_en  = active_r;
	assign o_rd_row = clamp_idx(row_pos);

	// Tags line up with the buffer's read latency
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tap_valid <= 1'b0;
			o_scan_done <= 1'b0;
		end else begin
			o_tap_valid <= active_r;
			o_scan_done <= last_rd_r;
		end
	end

	always_ff @(posedge i_clk) begin
		o_tap_row  <= tap_r;
		o_pad      <= pad;
		o_res_addr <= {row_r, col_r};
	end

	a_tap_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n) tap_r <= 2'd2);

endmodule

/* tb/clk_gen.sv */
module clk_gen #(
	parameter int RESET_CYCLES = 16
) (
	input  logic i_rst_req,
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// Reset at time zero and again on each request, released on a falling edge
	initial begin
		o_rst_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge o_clk);
			@(negedge o_clk);
			o_rst_n = 1'b1;
			@(posedge i_rst_req);
			o_rst_n = 1'b0;
		end
	end

endmodule

/* tb/conv_core_tb.sv */
module conv_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import img_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int STRIDE         = 1;
	localparam int DILATION       = 2;
	localparam int NUM_TESTS      = 2;
	localparam int RESET_CYCLES   = 16;
	localparam int SEED           = 32'h5dbe;
	localparam int NUM_WORDS      = IMG_WORDS + WEIGHT_WORDS;
	localparam int POS_PER_SIDE   = (IMG_DIM + STRIDE - 1) / STRIDE;
	localparam int NUM_OUT        = POS_PER_SIDE * POS_PER_SIDE;
	localparam int MAX_GAP        = 2;
	localparam int TAIL_CYCLES    = 20;
	localparam int MARGIN         = 200;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + NUM_WORDS * (MAX_GAP + 1)
		+ 3 * NUM_OUT + TAIL_CYCLES + MARGIN);

	logic      clk;
	logic      rst_n;
	logic      rst_req;
	logic      in_valid;
	word_t     in_data;
	logic      in_ready;
	logic      out_valid;
	pixel_t    out_data;
	out_addr_t out_addr;
	logic      exe_finish;

	integer    seed;
	int        mismatch_cnt;
	int        other_err_cnt;
	int        cycle_cnt;

	// Tables for the test that is running
	pixel_t    image [IMG_DIM * IMG_DIM];
	weight_t   weights [NUM_TAPS];
	word_t     stim_words [NUM_WORDS];
	out_addr_t exp_addr [NUM_OUT];
	pixel_t    exp_data [NUM_OUT];

	clk_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
		.i_rst_req(rst_req), .o_clk(clk), .o_rst_n(rst_n)
	);

	conv_core #(.STRIDE(STRIDE), .DILATION(DILATION)) conv_core_inst (
		.i_clk(clk), .i_rst_n(rst_n), .i_in_valid(in_valid), .i_in_data(in_data),
		.o_in_ready(in_ready), .o_out_valid(out_valid), .o_out_data(out_data),
		.o_out_addr(out_addr), .o_exe_finish(exe_finish)
	);

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_addr(input out_addr_t got, input out_addr_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is row %0d col %0d, expected row %0d col %0d",
				$time, what, got[11:6], got[5:0], exp[11:6], exp[5:0]);
			mismatch_cnt++;
		end
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			mismatch_cnt++;
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	// Zero outside the image, round, shift, saturate
	function automatic int conv_at(input int r, input int c);
		int sum;
		int pr;
		int pc;
		int q;
		sum = 0;
		for (int t = 0; t < 3; t++) begin
			for (int j = 0; j < 3; j++) begin
				pr = r + (t - 1) * DILATION;
				pc = c + (j - 1) * DILATION;
				if (pr >= 0 && pr < IMG_DIM && pc >= 0 && pc < IMG_DIM) begin
					sum += int'(weights[3 * t + j]) * int'(image[pr * IMG_DIM + pc]);
				end
			end
		end
		q = (sum + ROUND_BIAS) >>> FRAC_SHIFT;
		if (q < 0) begin
			q = 0;
		end else if (q > PIX_MAX) begin
			q = PIX_MAX;
		end
		return q;
	endfunction

	// Test 0 is fully random, test 1 has +127 taps, a bright patch and a dark patch
	task automatic fill_image(input int test);
		int p;
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				p = r * IMG_DIM + c;
				if (test == 0) begin
					image[p] = pixel_t'($random(seed));
				end else if (r >= 8 && r < 24 && c >= 8 && c < 24) begin
					image[p] = 8'hff;
				end else if (r >= 36 && r < 56 && c >= 36 && c < 56) begin
					image[p] = 8'h00;
				end else begin
					image[p] = pixel_t'($random(seed) & 31);
				end
			end
		end
		for (int n = 0; n < NUM_TAPS; n++) begin
			weights[n] = (test == 0) ? weight_t'($random(seed)) : weight_t'(127);
		end
	endtask

	task automatic build_tables(input int test);
		int idx;
		int sat_cnt;
		int zero_cnt;
		for (int k = 0; k < IMG_WORDS; k++) begin
			stim_words[k] = {image[4 * k], image[4 * k + 1], image[4 * k + 2], image[4 * k + 3]};
		end
		// Taps row-major, top byte first
		for (int k = 0; k < WEIGHT_WORDS; k++) begin
			stim_words[IMG_WORDS + k] = '0;
			for (int n = 0; n < 4; n++) begin
				if (4 * k + n < NUM_TAPS) begin
					stim_words[IMG_WORDS + k][31 - 8 * n -: 8] = weights[4 * k + n];
				end
			end
		end
		idx = 0;
		sat_cnt = 0;
		zero_cnt = 0;
		// Columns outer, rows inner
		for (int c = 0; c < IMG_DIM; c += STRIDE) begin
			for (int r = 0; r < IMG_DIM; r += STRIDE) begin
				exp_addr[idx] = {coord_t'(r), coord_t'(c)};
				exp_data[idx] = pixel_t'(conv_at(r, c));
				sat_cnt += (exp_data[idx] == 8'hff) ? 1 : 0;
				zero_cnt += (exp_data[idx] == 8'h00) ? 1 : 0;
				idx++;
			end
		end
		$display("Test %0d: %0d results expected, %0d at 255, %0d at 0",
			test, idx, sat_cnt, zero_cnt);
	endtask

	// ==================================================
	// Stimulus and response
	// ==================================================
	task automatic check_reset_state();
		repeat (3) @(negedge clk);
		check_flag(in_ready, 1'b0, "o_in_ready in reset");
		check_flag(exe_finish, 1'b0, "o_exe_finish in reset");
		check_flag(out_valid, 1'b0, "o_out_valid in reset");
	endtask

	task automatic send_words();
		int gap;
		logic taken;
		for (int k = 0; k < NUM_WORDS; k++) begin
			gap = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 1) : 0;
			in_valid = 1'b0;
			repeat (gap) @(negedge clk);
			in_valid = 1'b1;
			in_data  = stim_words[k];
			if (k > 0) begin
				check_flag(in_ready, 1'b1, "o_in_ready while loading");
			end
			// Ready seen on this falling edge means the next rising edge takes the word
			do begin
				taken = in_ready;
				@(negedge clk);
			end while (!taken);
		end
		in_valid = 1'b0;
		check_flag(in_ready, 1'b0, "o_in_ready after last weight");
	endtask

	task automatic collect_results();
		int idx;
		idx = 0;
		while (!exe_finish) begin
			if (out_valid) begin
				if (idx < NUM_OUT) begin
					check_addr(out_addr, exp_addr[idx], $sformatf("address of result %0d", idx));
					check_pixel(out_data, exp_data[idx], $sformatf("value of result %0d", idx));
				end else begin
					$display("Error at %0t ns: more than %0d results", $time, NUM_OUT);
					other_err_cnt++;
				end
				idx++;
			end
			check_flag(in_ready, 1'b0, "o_in_ready during convolution");
			@(negedge clk);
		end
		if (out_valid) begin
			$display("Error at %0t ns: a result pulsed with the finish flag", $time);
			other_err_cnt++;
		end
		if (idx != NUM_OUT) begin
			$display("Error: finish flag rose after %0d of %0d results", idx, NUM_OUT);
			other_err_cnt++;
		end
		// Finish must hold and the output must stay quiet
		repeat (TAIL_CYCLES) begin
			@(negedge clk);
			check_flag(exe_finish, 1'b1, "o_exe_finish after finish");
			if (out_valid) begin
				$display("Error at %0t ns: result pulse after the finish flag", $time);
				other_err_cnt++;
			end
		end
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial begin : main_flow
		$timeformat(-9, 0, "", 0);
		seed          = SEED;
		mismatch_cnt  = 0;
		other_err_cnt = 0;
		rst_req       = 1'b0;
		in_valid      = 1'b0;
		in_data       = '0;
		for (int test = 0; test < NUM_TESTS; test++) begin
			if (test > 0) begin
				rst_req = 1'b1;
				@(negedge clk);
				rst_req = 1'b0;
			end
			check_reset_state();
			fill_image(test);
			build_tables(test);
			@(posedge rst_n);
			send_words();
			collect_results();
		end
		$display("Error counts: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
		if ((mismatch_cnt == 0) && (other_err_cnt == 0)) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
